/* common/pkt_pkg.sv */
`default_nettype none

package pkt_pkg;

  // Width of one link beat
  localparam int DATA_WIDTH = 8;

  // Packet FIFO entries, a power of two
  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_ABITS = $clog2(FIFO_DEPTH);

  // Longest accepted frame in beats, trailer included
  // Must stay below FIFO_DEPTH so a legal frame always fits after release
  localparam int MAX_FRAME_LEN = 16;

  // Frame length counter, able to reach MAX_FRAME_LEN + 1
  localparam int LEN_BITS = $clog2(MAX_FRAME_LEN + 2);

endpackage

`default_nettype wire

/* packet_fifo/packet_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_fifo
  import pkt_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,

  output logic [FIFO_ABITS-1:0] level_o,

  input  wire                   drop_i,
  input  wire                   save_i,
  input  wire                   redo_i,
  input  wire                   next_i,

  input  wire                   valid_i,
  output logic                  ready_o,
  input  wire                   last_i,
  input  wire  [DATA_WIDTH-1:0] data_i,

  output logic                  valid_o,
  input  wire                   ready_i,
  output logic                  last_o,
  output logic [DATA_WIDTH-1:0] data_o
);

  // Beat storage with the last marker in the top bit
  logic [DATA_WIDTH:0] mem [FIFO_DEPTH];

  // Next free slot and end of committed data
  logic [FIFO_ABITS-1:0] waddr;
  logic [FIFO_ABITS-1:0] caddr;

  // Next beat to send and start of the unreleased frame
  logic [FIFO_ABITS-1:0] raddr;
  logic [FIFO_ABITS-1:0] rplay;

  logic wready;
  logic rvalid;

  logic store;
  logic fetch;

  logic [FIFO_ABITS-1:0] waddr_inc;
  logic [FIFO_ABITS-1:0] raddr_inc;
  logic [FIFO_ABITS-1:0] waddr_nx;
  logic [FIFO_ABITS-1:0] caddr_nx;
  logic [FIFO_ABITS-1:0] raddr_nx;
  logic [FIFO_ABITS-1:0] rplay_nx;
  logic [FIFO_ABITS-1:0] wlimit_nx;

  assign ready_o = wready;
  assign valid_o = rvalid;

  assign store = valid_i && wready;
  assign fetch = rvalid && ready_i;

  assign waddr_inc = store ? waddr + 1'b1 : waddr;

  // Drop discards everything written since the last commit,
  // including a beat stored in the same cycle
  assign waddr_nx = drop_i ? caddr : waddr_inc;
  assign caddr_nx = save_i ? waddr_inc : caddr;

  always_ff @(posedge clock) begin
    if (store) begin
      mem[waddr] <= {last_i, data_i};
    end
  end

  assign raddr_inc = fetch ? raddr + 1'b1 : raddr;

  // Redo rewinds to the start of the frame still waiting for release
  assign raddr_nx = redo_i ? rplay : raddr_inc;
  assign rplay_nx = next_i ? raddr_inc : rplay;

  // Read straight from the array so a rewind never leaves a stale prefetched beat
  assign {last_o, data_o} = mem[raddr];

  // One slot stays empty, which keeps the full count inside FIFO_ABITS bits.
  // The writer is bounded by the replay pointer, not the read pointer.
  assign wlimit_nx = waddr_nx + 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      waddr   <= '0;
      caddr   <= '0;
      raddr   <= '0;
      rplay   <= '0;
      wready  <= 1'b0;
      rvalid  <= 1'b0;
      level_o <= '0;
    end else begin
      waddr   <= waddr_nx;
      caddr   <= caddr_nx;
      raddr   <= raddr_nx;
      rplay   <= rplay_nx;
      wready  <= wlimit_nx != rplay_nx;
      // Compared with the registered commit pointer so a new frame shows up one cycle later
      rvalid  <= raddr_nx != caddr;
      level_o <= waddr_nx - rplay_nx;
    end
  end

  // Ready is registered so this covers the cycle after the last free slot went
  assert_no_store_full : assert property (
    @(posedge clock) disable iff (reset)
    store |-> (waddr + 1'b1) != rplay
  );

  // Commit and discard come from the frame checker and must exclude each other
  assert_save_drop : assert property (
    @(posedge clock) disable iff (reset)
    !(save_i && drop_i)
  );

  // A rewind only happens while the sender holds off reading
  assert_redo_idle : assert property (
    @(posedge clock) disable iff (reset)
    redo_i |-> !fetch
  );

endmodule

`default_nettype wire

/* verilog/frame_check.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_check
  import pkt_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,

  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  wire                   in_last_i,
  input  wire  [DATA_WIDTH-1:0] in_data_i,

  output logic                  wr_valid_o,
  input  wire                   wr_ready_i,
  output logic                  wr_last_o,
  output logic [DATA_WIDTH-1:0] wr_data_o,

  output logic                  save_o,
  output logic                  drop_o
);

  // Set while swallowing the rest of an oversize frame
  logic discard;

  logic [DATA_WIDTH-1:0] xor_q;
  logic [LEN_BITS-1:0]   len_q;

  logic [DATA_WIDTH-1:0] xor_nx;
  logic [LEN_BITS-1:0]   len_nx;
  logic                  over;
  logic                  accept;

  assign xor_nx = xor_q ^ in_data_i;
  assign len_nx = len_q + 1'b1;
  assign over   = len_nx > LEN_BITS'(MAX_FRAME_LEN);

  // The tail of a dropped frame is consumed regardless of FIFO space
  assign in_ready_o = discard || wr_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  // Beats go straight through to the FIFO, minus oversize ones
  assign wr_valid_o = in_valid_i && !discard && !over;
  assign wr_last_o  = in_last_i;
  assign wr_data_o  = in_data_i;

  assign save_o = accept && !discard && !over && in_last_i && (xor_nx == '0);
  assign drop_o = accept && !discard && (over || (in_last_i && (xor_nx != '0)));

  always_ff @(posedge clock) begin
    if (reset) begin
      discard <= 1'b0;
      xor_q   <= '0;
      len_q   <= '0;
    end else if (accept) begin
      if (discard) begin
        discard <= !in_last_i;
      end else if (over) begin
        // Only stay in discard if more beats follow
        discard <= !in_last_i;
        xor_q   <= '0;
        len_q   <= '0;
      end else if (in_last_i) begin
        xor_q <= '0;
        len_q <= '0;
      end else begin
        xor_q <= xor_nx;
        len_q <= len_nx;
      end
    end
  end

  assert_save_drop : assert property (
    @(posedge clock) disable iff (reset)
    !(save_o && drop_o)
  );

endmodule

`default_nettype wire

/* verilog/frame_sender.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_sender
  import pkt_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,

  input  wire                   rd_valid_i,
  output logic                  rd_ready_o,
  input  wire                   rd_last_i,
  input  wire  [DATA_WIDTH-1:0] rd_data_i,

  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output logic                  out_last_o,
  output logic [DATA_WIDTH-1:0] out_data_o,

  input  wire                   ack_i,
  input  wire                   nak_i,

  output logic                  next_o,
  output logic                  redo_o
);

  typedef enum logic {
    state_send,
    state_wait
  } state_t;

  state_t state;

  logic sending;
  logic waiting;
  logic last_xfer;

  assign sending = state == state_send;
  assign waiting = state == state_wait;

  // Pass-through while sending, closed off while the far end decides
  assign out_valid_o = sending && rd_valid_i;
  assign rd_ready_o  = sending && out_ready_i;
  assign out_last_o  = rd_last_i;
  assign out_data_o  = rd_data_i;

  assign last_xfer = out_valid_o && out_ready_i && rd_last_i;

  // Ack wins should both arrive at once
  assign next_o = waiting && ack_i;
  assign redo_o = waiting && nak_i && !ack_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= state_send;
    end else begin
      case (state)
        state_send: begin
          if (last_xfer) begin
            state <= state_wait;
          end
        end
        state_wait: begin
          if (ack_i || nak_i) begin
            state <= state_send;
          end
        end
        default: begin
          state <= state_send;
        end
      endcase
    end
  end

  assert_ack_nak : assert property (
    @(posedge clock) disable iff (reset)
    waiting |-> !(ack_i && nak_i)
  );

endmodule

`default_nettype wire

/* verilog/pkt_link_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pkt_link_top
  import pkt_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,

  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  wire                   in_last_i,
  input  wire  [DATA_WIDTH-1:0] in_data_i,

  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output logic                  out_last_o,
  output logic [DATA_WIDTH-1:0] out_data_o,

  input  wire                   ack_i,
  input  wire                   nak_i,

  output logic [FIFO_ABITS-1:0] level_o
);

  // Checker to FIFO write side
  logic                  wr_valid;
  logic                  wr_ready;
  logic                  wr_last;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  fifo_save;
  logic                  fifo_drop;

  // FIFO read side to sender
  logic                  rd_valid;
  logic                  rd_ready;
  logic                  rd_last;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  fifo_next;
  logic                  fifo_redo;

  frame_check frame_check_inst (
    .clock      (clock),
    .reset      (reset),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_last_i  (in_last_i),
    .in_data_i  (in_data_i),
    .wr_valid_o (wr_valid),
    .wr_ready_i (wr_ready),
    .wr_last_o  (wr_last),
    .wr_data_o  (wr_data),
    .save_o     (fifo_save),
    .drop_o     (fifo_drop)
  );

  packet_fifo packet_fifo_inst (
    .clock   (clock),
    .reset   (reset),
    .level_o (level_o),
    .drop_i  (fifo_drop),
    .save_i  (fifo_save),
    .redo_i  (fifo_redo),
    .next_i  (fifo_next),
    .valid_i (wr_valid),
    .ready_o (wr_ready),
    .last_i  (wr_last),
    .data_i  (wr_data),
    .valid_o (rd_valid),
    .ready_i (rd_ready),
    .last_o  (rd_last),
    .data_o  (rd_data)
  );

  frame_sender frame_sender_inst (
    .clock       (clock),
    .reset       (reset),
    .rd_valid_i  (rd_valid),
    .rd_ready_o  (rd_ready),
    .rd_last_i   (rd_last),
    .rd_data_i   (rd_data),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_last_o  (out_last_o),
    .out_data_o  (out_data_o),
    .ack_i       (ack_i),
    .nak_i       (nak_i),
    .next_o      (fifo_next),
    .redo_o      (fifo_redo)
  );

endmodule

`default_nettype wire

/* tb/pkt_link_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pkt_link_checker
  import pkt_pkg::*;
(
  input  wire                  clock,
  input  wire                  reset,
  input  wire                  in_valid_i,
  input  wire                  in_ready_i,
  input  wire                  in_last_i,
  input  wire [DATA_WIDTH-1:0] in_data_i,
  input  wire                  out_valid_i,
  input  wire                  out_ready_i,
  input  wire                  out_last_i,
  input  wire [DATA_WIDTH-1:0] out_data_i,
  input  wire                  ack_i,
  output int                   error_count_o,
  output int                   pending_o
);

  // Frames that passed the rules, bytes flattened, lengths alongside
  logic [DATA_WIDTH-1:0] exp_bytes [$];
  int                    exp_lens [$];
  // Frame currently arriving at the input
  logic [DATA_WIDTH-1:0] cur_bytes [$];
  logic [DATA_WIDTH-1:0] cur_xor = '0;
  int                    out_idx = 0;
  int                    released = 0;
  int                    queued = 0;
  int                    errors = 0;

  assign error_count_o = errors;
  assign pending_o     = queued;

  // Head frame leaves the queue only once the far end accepts it
  function automatic void release_head();
    int n;
    if (queued == 0) begin
      $display("Ack arrived while no frame was waiting for release");
      errors++;
    end else begin
      n = exp_lens.pop_front();
      repeat (n) begin
        void'(exp_bytes.pop_front());
      end
      queued--;
      released++;
    end
  endfunction

  function automatic void check_beat();
    logic exp_last;
    if (queued == 0 || out_idx >= exp_lens[0]) begin
      $display("Output beat %h at position %0d belongs to no expected frame",
               out_data_i, out_idx);
      errors++;
    end else begin
      exp_last = out_idx == exp_lens[0] - 1;
      if (out_data_i !== exp_bytes[out_idx]) begin
        $display("error frame_data %0d beat %0d: expected %h, actual %h",
                 released, out_idx, exp_bytes[out_idx], out_data_i);
        errors++;
      end
      if (out_last_i !== exp_last) begin
        $display("error frame_last %0d beat %0d: expected %0b, actual %0b",
                 released, out_idx, exp_last, out_last_i);
        errors++;
      end
    end
    // A nak replays the same head, so the position restarts either way
    out_idx = out_last_i ? 0 : out_idx + 1;
  endfunction

  always @(posedge clock) begin
    if (!reset) begin
      if (in_valid_i && in_ready_i) begin
        cur_bytes.push_back(in_data_i);
        cur_xor = cur_xor ^ in_data_i;
        if (in_last_i) begin
          // Kept only if short enough and all bytes XOR to zero
          if (cur_bytes.size() <= MAX_FRAME_LEN && cur_xor == '0) begin
            foreach (cur_bytes[i]) begin
              exp_bytes.push_back(cur_bytes[i]);
            end
            exp_lens.push_back(cur_bytes.size());
            queued++;
          end
          cur_bytes.delete();
          cur_xor = '0;
        end
      end
      if (out_valid_i && out_ready_i) begin
        check_beat();
      end
      if (ack_i) begin
        release_head();
      end
    end
  end

endmodule

`default_nettype wire

/* tb/pkt_link_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pkt_link_tb
  import pkt_pkg::*;
();

  localparam int     NUM_FRAMES = 60;
  localparam int     TIMEOUT    = 5000;
  localparam int     IDLE_CHECK = 20;
  localparam integer SEED       = 32'h0717_4415;

  logic                  clock;
  logic                  reset;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic                  in_last_i;
  logic [DATA_WIDTH-1:0] in_data_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  out_last_o;
  logic [DATA_WIDTH-1:0] out_data_o;
  logic                  ack_i;
  logic                  nak_i;
  logic [FIFO_ABITS-1:0] level_o;

  integer stim_seed;
  integer ready_seed;
  integer resp_seed;
  int     checker_errors;
  int     pending;
  int     status_errors = 0;
  int     timeout_errors = 0;
  logic   aborted = 1'b0;

  initial clock = 1'b0;
  always #5 clock = ~clock;

  pkt_link_top pkt_link_top_inst (.*);

  pkt_link_checker checker_inst (
    .clock         (clock),
    .reset         (reset),
    .in_valid_i    (in_valid_i),
    .in_ready_i    (in_ready_o),
    .in_last_i     (in_last_i),
    .in_data_i     (in_data_i),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_last_i    (out_last_o),
    .out_data_i    (out_data_o),
    .ack_i         (ack_i),
    .error_count_o (checker_errors),
    .pending_o     (pending)
  );

  task automatic expect_value(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
      status_errors++;
    end
  endtask

  task automatic give_up(input string what);
    $display("Timed out waiting for %s", what);
    timeout_errors++;
    aborted = 1'b1;
  endtask

  // Holds one beat on the input until the DUT takes it
  task automatic drive_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
    int waited;
    @(negedge clock);
    in_valid_i = 1'b1;
    in_data_i  = data;
    in_last_i  = last;
    waited = 0;
    while (!in_ready_o && waited < TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (!in_ready_o) begin
      give_up("the DUT to accept an input beat");
    end
  endtask

  // Trailer cancels the XOR in about 70 % of frames
  task automatic send_frame(input int len);
    logic [DATA_WIDTH-1:0] data;
    logic [DATA_WIDTH-1:0] parity;
    parity = '0;
    for (int i = 0; i < len && !aborted; i++) begin
      data = DATA_WIDTH'($random(stim_seed));
      if (i == len - 1 && $unsigned($random(stim_seed)) % 10 < 7) begin
        data = parity;
      end
      parity = parity ^ data;
      if ($unsigned($random(stim_seed)) % 5 == 0) begin
        @(negedge clock);
        in_valid_i = 1'b0;
      end
      drive_beat(data, i == len - 1);
    end
  endtask

  // Output back-pressure, ready about three cycles in four
  initial begin : back_pressure
    ready_seed  = SEED + 1;
    out_ready_i = 1'b0;
    forever begin
      @(negedge clock);
      out_ready_i = ($unsigned($random(ready_seed)) % 4) != 0;
    end
  end

  // Far end answers each final beat after a short delay, nak about one time in four
  initial begin : responder
    int delay;
    resp_seed = SEED + 2;
    ack_i = 1'b0;
    nak_i = 1'b0;
    forever begin
      @(posedge clock);
      if (!reset && out_valid_o && out_ready_i && out_last_o) begin
        delay = int'($unsigned($random(resp_seed)) % 6);
        repeat (delay + 1) @(negedge clock);
        if ($unsigned($random(resp_seed)) % 4 == 0) begin
          nak_i = 1'b1;
        end else begin
          ack_i = 1'b1;
        end
        @(negedge clock);
        ack_i = 1'b0;
        nak_i = 1'b0;
      end
    end
  end

  initial begin : stimulus
    int waited;
    int busy;
    reset      = 1'b1;
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
    in_data_i  = '0;
    stim_seed  = SEED;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    expect_value("reset_out_valid", 0, int'(out_valid_o));
    expect_value("reset_in_ready", 0, int'(in_ready_o));
    expect_value("reset_level", 0, int'(level_o));
    waited = 0;
    while (!in_ready_o && waited < TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (!in_ready_o) begin
      give_up("input ready after reset");
    end
    // Lengths of 1 to 20 beats, anything past 16 is oversize
    for (int frame = 0; frame < NUM_FRAMES && !aborted; frame++) begin
      send_frame(1 + int'($unsigned($random(stim_seed)) % 20));
    end
    @(negedge clock);
    in_valid_i = 1'b0;
    waited = 0;
    while (!aborted && (pending != 0 || level_o != '0) && waited < TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (!aborted && pending != 0) begin
      give_up("every queued frame to be acknowledged");
    end else if (!aborted) begin
      expect_value("final_level", 0, int'(level_o));
    end
    busy = 0;
    repeat (IDLE_CHECK) begin
      @(negedge clock);
      if (!aborted && out_valid_o) begin
        busy = 1;
      end
    end
    expect_value("idle_out_valid", 0, busy);
    $display("Error counts: %0d checker, %0d status, %0d timeout",
             checker_errors, status_errors, timeout_errors);
    if (checker_errors + status_errors + timeout_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pkt_link.f */
common/pkt_pkg.sv
packet_fifo/packet_fifo.sv
verilog/frame_check.sv
verilog/frame_sender.sv
verilog/pkt_link_top.sv
tb/pkt_link_checker.sv
tb/pkt_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the pkt_link testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pkt_link_tb -f pkt_link.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vpkt_link_tb > sim.log 2>&1 || echo "Simulation exited with a non-zero status"
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
